/* mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // tlb geometry
    localparam int tlb_entries = 32;
    localparam int tlb_idx_w   = 5;
    localparam int asid_w      = 8;
    localparam int vpn2_w      = 19;
    localparam int pfn_w       = 20;

    // segment boundaries
    localparam logic [31:0] kseg0_base = 32'h8000_0000;
    localparam logic [31:0] kseg1_base = 32'hA000_0000;
    localparam logic [31:0] kseg2_base = 32'hC000_0000;

    // translation exceptions
    localparam int exc_w = 3;
    localparam logic [exc_w-1:0] exc_none      = 3'd0;
    localparam logic [exc_w-1:0] exc_refill_l  = 3'd1;
    localparam logic [exc_w-1:0] exc_refill_s  = 3'd2;
    localparam logic [exc_w-1:0] exc_invalid_l = 3'd3;
    localparam logic [exc_w-1:0] exc_invalid_s = 3'd4;
    localparam logic [exc_w-1:0] exc_modified  = 3'd5;

    // cp0 register numbers
    localparam logic [4:0] cp0_index    = 5'd0;
    localparam logic [4:0] cp0_random   = 5'd1;
    localparam logic [4:0] cp0_entrylo0 = 5'd2;
    localparam logic [4:0] cp0_entrylo1 = 5'd3;
    localparam logic [4:0] cp0_entryhi  = 5'd10;

    // tlb maintenance ops
    localparam logic [1:0] op_tlbr  = 2'd0;
    localparam logic [1:0] op_tlbwi = 2'd1;
    localparam logic [1:0] op_tlbwr = 2'd2;
    localparam logic [1:0] op_tlbp  = 2'd3;

    localparam logic [2:0] cache_c_cached = 3'd3;

    // entrylo word, raw for cp0 access, by field inside the tlb
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [5:0]       rsvd;
            logic [pfn_w-1:0] pfn;
            logic [2:0]       c;
            logic             d;
            logic             v;
            logic             g;
        } f;
    } entrylo_u;

endpackage

`default_nettype wire

/* mmu_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

interface tlb_cfg_if import mmu_pkg::*; ();
    logic                  wr_en;
    logic [tlb_idx_w-1:0]  wr_idx;
    logic [vpn2_w-1:0]     entryhi_vpn2;
    logic [asid_w-1:0]     asid;
    entrylo_u              entrylo0;
    entrylo_u              entrylo1;
    logic                  probe_en;
    // entry addressed by wr_idx
    logic [vpn2_w-1:0]     rd_vpn2;
    logic [asid_w-1:0]     rd_asid;
    entrylo_u              rd_lo0;
    entrylo_u              rd_lo1;
    logic                  probe_hit;
    logic [tlb_idx_w-1:0]  probe_idx;

    modport regs (
        output wr_en, wr_idx, entryhi_vpn2, asid, entrylo0, entrylo1, probe_en,
        input  rd_vpn2, rd_asid, rd_lo0, rd_lo1, probe_hit, probe_idx
    );

    modport array (
        input  wr_en, wr_idx, entryhi_vpn2, asid, entrylo0, entrylo1, probe_en,
        output rd_vpn2, rd_asid, rd_lo0, rd_lo1, probe_hit, probe_idx
    );
endinterface

interface tlb_lookup_if import mmu_pkg::*; ();
    // vaddr[31:12]
    logic [pfn_w-1:0] vpn;
    logic             hit;
    logic [pfn_w-1:0] pfn;
    logic [2:0]       c;
    logic             d;
    logic             v;

    modport port  (output vpn, input hit, pfn, c, d, v);
    modport array (input vpn, output hit, pfn, c, d, v);
endinterface

`default_nettype wire

/* tlb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_regs import mmu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    input  logic [4:0]  cp0_raddr,
    output logic [31:0] cp0_rdata,
    input  logic        op_valid,
    input  logic [1:0]  op_code,
    output logic        op_done,
    tlb_cfg_if.regs     cfg
);

    logic                 index_p;
    logic [tlb_idx_w-1:0] index_r;
    logic [tlb_idx_w-1:0] random_r;
    logic [vpn2_w-1:0]    hi_vpn2;
    logic [asid_w-1:0]    hi_asid;
    entrylo_u             lo0;
    entrylo_u             lo1;

    // array side, writes and reads go through wr_idx
    assign cfg.wr_en        = op_valid && (op_code == op_tlbwi || op_code == op_tlbwr);
    assign cfg.wr_idx       = (op_code == op_tlbwr) ? random_r : index_r;
    assign cfg.entryhi_vpn2 = hi_vpn2;
    assign cfg.asid         = hi_asid;
    assign cfg.entrylo0     = lo0;
    assign cfg.entrylo1     = lo1;
    assign cfg.probe_en     = op_valid && op_code == op_tlbp;

    always_comb begin
        case (cp0_raddr)
            cp0_index:    cp0_rdata = {index_p, 26'b0, index_r};
            cp0_random:   cp0_rdata = {27'b0, random_r};
            cp0_entrylo0: cp0_rdata = lo0.raw;
            cp0_entrylo1: cp0_rdata = lo1.raw;
            cp0_entryhi:  cp0_rdata = {hi_vpn2, 5'b0, hi_asid};
            default:      cp0_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_p  <= 1'b0;
            index_r  <= '0;
            random_r <= tlb_idx_w'(tlb_entries - 1);
            hi_vpn2  <= '0;
            hi_asid  <= '0;
            lo0      <= '0;
            lo1      <= '0;
            op_done  <= 1'b0;
        end else begin
            // wraps 0 -> 31 on its own
            random_r <= random_r - 1'b1;
            op_done  <= op_valid;
            if (cp0_we) begin
                case (cp0_addr)
                    cp0_index: index_r <= cp0_wdata[tlb_idx_w-1:0];
                    cp0_entrylo0: lo0.raw <= {6'b0, cp0_wdata[25:0]};
                    cp0_entrylo1: lo1.raw <= {6'b0, cp0_wdata[25:0]};
                    cp0_entryhi: begin
                        hi_vpn2 <= cp0_wdata[31:13];
                        hi_asid <= cp0_wdata[asid_w-1:0];
                    end
                    default: ;
                endcase
            end
            // ops win over a cp0 write in the same cycle
            if (op_valid && op_code == op_tlbr) begin
                hi_vpn2 <= cfg.rd_vpn2;
                hi_asid <= cfg.rd_asid;
                lo0     <= cfg.rd_lo0;
                lo1     <= cfg.rd_lo1;
            end
            if (cfg.probe_en) begin
                index_p <= !cfg.probe_hit;
                if (cfg.probe_hit) begin
                    index_r <= cfg.probe_idx;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tlb_array.sv */
`timescale 1ns/1ns
`default_nettype none

module tlb_array import mmu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    tlb_cfg_if.array     cfg,
    tlb_lookup_if.array  ilk,
    tlb_lookup_if.array  dlk
);

    logic [vpn2_w-1:0]      vpn2_q [tlb_entries];
    logic [asid_w-1:0]      asid_q [tlb_entries];
    logic [tlb_entries-1:0] g_q;
    // per page, index 0 is the even page
    logic [pfn_w-1:0]       pfn_q  [2][tlb_entries];
    logic [2:0]             c_q    [2][tlb_entries];
    logic [tlb_entries-1:0] d_q    [2];
    logic [tlb_entries-1:0] v_q    [2];

    entrylo_u               wr_lo  [2];

    logic [tlb_idx_w:0]     ifind;
    logic [tlb_idx_w:0]     dfind;
    logic [tlb_idx_w:0]     pfind;
    logic [tlb_idx_w-1:0]   iidx;
    logic [tlb_idx_w-1:0]   didx;

    // {hit, idx}, lowest matching index wins
    function automatic logic [tlb_idx_w:0] find_entry(
        input logic [vpn2_w-1:0] vpn2,
        input logic [asid_w-1:0] asid
    );
        logic [tlb_idx_w:0] res;
        res = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (vpn2_q[i] == vpn2 && (g_q[i] || asid_q[i] == asid)) begin
                res = {1'b1, tlb_idx_w'(i)};
            end
        end
        return res;
    endfunction

    function automatic entrylo_u pack_lo(
        input logic                 page,
        input logic [tlb_idx_w-1:0] idx
    );
        entrylo_u lo;
        lo.raw   = '0;
        lo.f.pfn = pfn_q[page][idx];
        lo.f.c   = c_q[page][idx];
        lo.f.d   = d_q[page][idx];
        lo.f.v   = v_q[page][idx];
        lo.f.g   = g_q[idx];
        return lo;
    endfunction

    assign wr_lo[0] = cfg.entrylo0;
    assign wr_lo[1] = cfg.entrylo1;

    always_ff @(posedge clk) begin
        if (cfg.wr_en) begin
            vpn2_q[cfg.wr_idx] <= cfg.entryhi_vpn2;
            asid_q[cfg.wr_idx] <= cfg.asid;
            g_q[cfg.wr_idx]    <= wr_lo[0].f.g & wr_lo[1].f.g;
            for (int p = 0; p < 2; p++) begin
                pfn_q[p][cfg.wr_idx] <= wr_lo[p].f.pfn;
                c_q[p][cfg.wr_idx]   <= wr_lo[p].f.c;
                d_q[p][cfg.wr_idx]   <= wr_lo[p].f.d;
            end
        end
    end

    // only valid bits are cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_q[0] <= '0;
            v_q[1] <= '0;
        end else if (cfg.wr_en) begin
            for (int p = 0; p < 2; p++) begin
                v_q[p][cfg.wr_idx] <= wr_lo[p].f.v;
            end
        end
    end

    always_comb begin
        ifind = find_entry(ilk.vpn[vpn2_w:1], cfg.asid);
        dfind = find_entry(dlk.vpn[vpn2_w:1], cfg.asid);
        pfind = find_entry(cfg.entryhi_vpn2, cfg.asid);
    end

    assign iidx = ifind[tlb_idx_w-1:0];
    assign didx = dfind[tlb_idx_w-1:0];

    assign ilk.hit = ifind[tlb_idx_w];
    assign ilk.pfn = pfn_q[ilk.vpn[0]][iidx];
    assign ilk.c   = c_q[ilk.vpn[0]][iidx];
    assign ilk.d   = d_q[ilk.vpn[0]][iidx];
    assign ilk.v   = v_q[ilk.vpn[0]][iidx];

    assign dlk.hit = dfind[tlb_idx_w];
    assign dlk.pfn = pfn_q[dlk.vpn[0]][didx];
    assign dlk.c   = c_q[dlk.vpn[0]][didx];
    assign dlk.d   = d_q[dlk.vpn[0]][didx];
    assign dlk.v   = v_q[dlk.vpn[0]][didx];

    assign cfg.probe_hit = cfg.probe_en & pfind[tlb_idx_w];
    assign cfg.probe_idx = pfind[tlb_idx_w-1:0];

    // read port for tlbr, g goes back into both words
    always_comb begin
        cfg.rd_vpn2 = vpn2_q[cfg.wr_idx];
        cfg.rd_asid = asid_q[cfg.wr_idx];
        cfg.rd_lo0  = pack_lo(1'b0, cfg.wr_idx);
        cfg.rd_lo1  = pack_lo(1'b1, cfg.wr_idx);
    end

endmodule

`default_nettype wire

/* addr_xlate.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_xlate import mmu_pkg::*; #(
    parameter int write_port = 0
)(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic [31:0]      vaddr,
    input  logic             wr,
    output logic             done,
    output logic [31:0]      paddr,
    output logic [exc_w-1:0] exc,
    output logic             cached,
    tlb_lookup_if.port       lk
);

    logic             st;
    logic [31:0]      paddr_d;
    logic [exc_w-1:0] exc_d;
    logic             cached_d;

    // fetch port never sees a store
    assign st     = (write_port != 0) && wr;
    assign lk.vpn = vaddr[31:12];

    always_comb begin
        if (vaddr >= kseg0_base && vaddr < kseg1_base) begin
            paddr_d  = vaddr - kseg0_base;
            exc_d    = exc_none;
            cached_d = 1'b1;
        end else if (vaddr >= kseg1_base && vaddr < kseg2_base) begin
            paddr_d  = vaddr - kseg1_base;
            exc_d    = exc_none;
            cached_d = 1'b0;
        end else begin
            // kuseg, kseg2/3 go through the tlb
            paddr_d = {lk.pfn, vaddr[11:0]};
            if (!lk.hit) begin
                exc_d = st ? exc_refill_s : exc_refill_l;
            end else if (!lk.v) begin
                exc_d = st ? exc_invalid_s : exc_invalid_l;
            end else if (st && !lk.d) begin
                exc_d = exc_modified;
            end else begin
                exc_d = exc_none;
            end
            cached_d = (exc_d == exc_none) && (lk.c == cache_c_cached);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            exc    <= exc_none;
            cached <= 1'b0;
        end else begin
            done   <= req;
            exc    <= req ? exc_d : exc_none;
            cached <= req & cached_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            paddr <= paddr_d;
        end
    end

endmodule

`default_nettype wire

/* mmu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_top import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    // cp0 access
    input  logic             cp0_we,
    input  logic [4:0]       cp0_addr,
    input  logic [31:0]      cp0_wdata,
    input  logic [4:0]       cp0_raddr,
    output logic [31:0]      cp0_rdata,
    // tlb maintenance
    input  logic             op_valid,
    input  logic [1:0]       op_code,
    output logic             op_done,
    // fetch port
    input  logic             inst_req,
    input  logic [31:0]      inst_vaddr,
    output logic             inst_done,
    output logic [31:0]      inst_paddr,
    output logic [exc_w-1:0] inst_exc,
    output logic             inst_cached,
    // data port
    input  logic             data_req,
    input  logic [31:0]      data_vaddr,
    input  logic             data_wr,
    output logic             data_done,
    output logic [31:0]      data_paddr,
    output logic [exc_w-1:0] data_exc,
    output logic             data_cached
);

    tlb_cfg_if    cfg_if ();
    tlb_lookup_if ilk_if ();
    tlb_lookup_if dlk_if ();

    tlb_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cp0_we    (cp0_we),
        .cp0_addr  (cp0_addr),
        .cp0_wdata (cp0_wdata),
        .cp0_raddr (cp0_raddr),
        .cp0_rdata (cp0_rdata),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .op_done   (op_done),
        .cfg       (cfg_if.regs)
    );

    tlb_array array_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg_if.array),
        .ilk   (ilk_if.array),
        .dlk   (dlk_if.array)
    );

    addr_xlate #(.write_port(0)) inst_xlate_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (inst_req),
        .vaddr  (inst_vaddr),
        .wr     (1'b0),
        .done   (inst_done),
        .paddr  (inst_paddr),
        .exc    (inst_exc),
        .cached (inst_cached),
        .lk     (ilk_if.port)
    );

    addr_xlate #(.write_port(1)) data_xlate_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (data_req),
        .vaddr  (data_vaddr),
        .wr     (data_wr),
        .done   (data_done),
        .paddr  (data_paddr),
        .exc    (data_exc),
        .cached (data_cached),
        .lk     (dlk_if.port)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

    // held over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* mmu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_checker import mmu_pkg::*; (
    input logic             clk,
    input logic             rst_n,
    input logic             inst_req,
    input logic             inst_done,
    input logic [exc_w-1:0] inst_exc,
    input logic             data_req,
    input logic             data_done,
    input logic [exc_w-1:0] data_exc,
    input logic             op_valid,
    input logic             op_done
);

    // one cycle turnaround, no stall
    inst_turn_a: assert property (@(posedge clk) disable iff (!rst_n)
        inst_done == $past(inst_req))
        else $error("inst_done does not follow inst_req by one cycle");

    data_turn_a: assert property (@(posedge clk) disable iff (!rst_n)
        data_done == $past(data_req))
        else $error("data_done does not follow data_req by one cycle");

    op_turn_a: assert property (@(posedge clk) disable iff (!rst_n)
        op_done == $past(op_valid))
        else $error("op_done does not follow op_valid by one cycle");

    inst_exc_a: assert property (@(posedge clk) (inst_exc != exc_none) |-> inst_done)
        else $error("inst_exc raised without inst_done");

    data_exc_a: assert property (@(posedge clk) (data_exc != exc_none) |-> data_done)
        else $error("data_exc raised without data_done");

    reset_a: assert property (@(posedge clk) !rst_n |->
        (!inst_done && !data_done && !op_done && inst_exc == exc_none && data_exc == exc_none))
        else $error("outputs not idle during reset");

endmodule

`default_nettype wire

/* mmu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_tb import mmu_pkg::*; ();

    localparam int n_kseg  = 60;
    localparam int n_map   = 150;
    localparam int n_tlbr  = 20;
    localparam int n_tlbp  = 30;
    localparam int n_tlbwr = 20;
    // transactions per phase at up to 4 cycles each plus reset slack
    localparam int max_cycles = 4 * (tlb_entries * 5 + n_kseg + n_map * 2 + n_tlbr * 5
                                     + n_tlbp * 3 + n_tlbwr * 6) + 100;

    logic             clk;
    logic             rst_n;
    logic             cp0_we;
    logic [4:0]       cp0_addr;
    logic [31:0]      cp0_wdata;
    logic [4:0]       cp0_raddr;
    logic [31:0]      cp0_rdata;
    logic             op_valid;
    logic [1:0]       op_code;
    logic             op_done;
    logic             inst_req;
    logic [31:0]      inst_vaddr;
    logic             inst_done;
    logic [31:0]      inst_paddr;
    logic [exc_w-1:0] inst_exc;
    logic             inst_cached;
    logic             data_req;
    logic [31:0]      data_vaddr;
    logic             data_wr;
    logic             data_done;
    logic [31:0]      data_paddr;
    logic [exc_w-1:0] data_exc;
    logic             data_cached;

    // reference copy of the tlb and the cp0 registers
    logic [vpn2_w-1:0]    m_vpn2  [tlb_entries];
    logic [asid_w-1:0]    m_asid  [tlb_entries];
    entrylo_u             m_lo0   [tlb_entries];
    entrylo_u             m_lo1   [tlb_entries];
    bit                   m_known [tlb_entries];
    logic [vpn2_w-1:0]    hi_vpn2;
    logic [asid_w-1:0]    hi_asid;
    entrylo_u             lo0;
    entrylo_u             lo1;
    logic                 idx_p;
    logic [tlb_idx_w-1:0] idx_r;
    bit                   used_vpn2 [bit [vpn2_w-1:0]];

    int n_checks = 0;
    int n_errors = 0;
    int cycles = 0;
    // rising edges seen with reset released
    int live_edges = 0;

    tb_clkgen clkgen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mmu_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cp0_we      (cp0_we),
        .cp0_addr    (cp0_addr),
        .cp0_wdata   (cp0_wdata),
        .cp0_raddr   (cp0_raddr),
        .cp0_rdata   (cp0_rdata),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .op_done     (op_done),
        .inst_req    (inst_req),
        .inst_vaddr  (inst_vaddr),
        .inst_done   (inst_done),
        .inst_paddr  (inst_paddr),
        .inst_exc    (inst_exc),
        .inst_cached (inst_cached),
        .data_req    (data_req),
        .data_vaddr  (data_vaddr),
        .data_wr     (data_wr),
        .data_done   (data_done),
        .data_paddr  (data_paddr),
        .data_exc    (data_exc),
        .data_cached (data_cached)
    );

    bind mmu_top mmu_checker checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_req  (inst_req),
        .inst_done (inst_done),
        .inst_exc  (inst_exc),
        .data_req  (data_req),
        .data_done (data_done),
        .data_exc  (data_exc),
        .op_valid  (op_valid),
        .op_done   (op_done)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n) begin
            live_edges <= live_edges + 1;
        end
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    // mapped vpn2 never seen before
    // top bits 10 would land in kseg0/1
    function automatic logic [vpn2_w-1:0] fresh_vpn2();
        logic [31:0]       r;
        logic [vpn2_w-1:0] v;
        do begin
            r = $urandom;
            v = r[vpn2_w-1:0];
            if (v[18]) begin
                v[17] = 1'b1;
            end
        end while (used_vpn2.exists(v));
        used_vpn2[v] = 1'b1;
        return v;
    endfunction

    function automatic logic [asid_w-1:0] random_asid();
        logic [31:0] r;
        r = $urandom;
        return {6'b0, r[1:0]};
    endfunction

    function automatic entrylo_u rand_lo();
        logic [31:0] r;
        entrylo_u    lo;
        r = $urandom;
        lo.raw   = '0;
        lo.f.pfn = r[19:0];
        lo.f.c   = r[22:20];
        lo.f.d   = r[23];
        // mostly valid
        lo.f.v   = r[24] | r[25];
        lo.f.g   = r[26];
        return lo;
    endfunction

    function automatic entrylo_u with_g(input entrylo_u lo, input logic g);
        entrylo_u res;
        res     = lo;
        res.f.g = g;
        return res;
    endfunction

    function automatic void model_find(input logic [vpn2_w-1:0] vpn2, output bit found,
                                       output int slot);
        found = 1'b0;
        slot  = 0;
        for (int e = 0; e < tlb_entries; e++) begin
            if (!found && m_known[e] && m_vpn2[e] == vpn2 &&
                ((m_lo0[e].f.g && m_lo1[e].f.g) || m_asid[e] == hi_asid)) begin
                found = 1'b1;
                slot  = e;
            end
        end
    endfunction

    function automatic void store_entry(input int slot);
        m_vpn2[slot]  = hi_vpn2;
        m_asid[slot]  = hi_asid;
        m_lo0[slot]   = lo0;
        m_lo1[slot]   = lo1;
        m_known[slot] = 1'b1;
    endfunction

    function automatic void predict(input logic [31:0] va, input bit st,
                                    output logic [31:0] pa, output logic [exc_w-1:0] ex,
                                    output bit ca);
        bit       found;
        int       slot;
        entrylo_u pg;
        pa = '0;
        ex = exc_none;
        ca = 1'b0;
        if (va >= kseg0_base && va < kseg1_base) begin
            pa = va - kseg0_base;
            ca = 1'b1;
        end else if (va >= kseg1_base && va < kseg2_base) begin
            pa = va - kseg1_base;
        end else begin
            model_find(va[31:13], found, slot);
            pg = va[12] ? m_lo1[slot] : m_lo0[slot];
            pa = {pg.f.pfn, va[11:0]};
            if (!found) begin
                ex = st ? exc_refill_s : exc_refill_l;
            end else if (!pg.f.v) begin
                ex = st ? exc_invalid_s : exc_invalid_l;
            end else if (st && !pg.f.d) begin
                ex = exc_modified;
            end
            ca = (ex == exc_none) && (pg.f.c == cache_c_cached);
        end
    endfunction

    function automatic logic [31:0] unmapped_va();
        logic [31:0] r;
        r = $urandom;
        return (r[31] ? kseg1_base : kseg0_base) + {3'b0, r[28:0]};
    endfunction

    // one in sixteen misses on a fresh vpn2
    function automatic logic [31:0] mapped_va();
        logic [31:0]       r;
        logic [vpn2_w-1:0] vpn2;
        r = $urandom;
        if (r[3:0] == 4'd0) begin
            vpn2 = fresh_vpn2();
        end else begin
            vpn2 = m_vpn2[r[8:4]];
        end
        return {vpn2, r[9], r[21:10]};
    endfunction

    task automatic write_cp0(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        #10;
        cp0_we    = 1'b1;
        cp0_addr  = a;
        cp0_wdata = d;
        @(posedge clk);
        #10;
        cp0_we = 1'b0;
        case (a)
            cp0_index:    idx_r = d[tlb_idx_w-1:0];
            cp0_entrylo0: lo0.raw = {6'b0, d[25:0]};
            cp0_entrylo1: lo1.raw = {6'b0, d[25:0]};
            cp0_entryhi: begin
                hi_vpn2 = d[31:13];
                hi_asid = d[asid_w-1:0];
            end
            default: ;
        endcase
    endtask

    task automatic read_check(input string name, input logic [4:0] a, input logic [31:0] exp);
        @(posedge clk);
        #10;
        cp0_raddr = a;
        @(negedge clk);
        check_val(name, exp, cp0_rdata);
    endtask

    task automatic load_entry(input logic [vpn2_w-1:0] vpn2, input logic [asid_w-1:0] asid,
                              input entrylo_u a, input entrylo_u b);
        write_cp0(cp0_entryhi, {vpn2, 5'b0, asid});
        write_cp0(cp0_entrylo0, a.raw);
        write_cp0(cp0_entrylo1, b.raw);
    endtask

    task automatic do_op(input logic [1:0] code);
        bit found;
        int slot;
        @(posedge clk);
        #10;
        op_valid = 1'b1;
        op_code  = code;
        @(posedge clk);
        #10;
        op_valid = 1'b0;
        @(negedge clk);
        while (!op_done) begin
            @(negedge clk);
        end
        case (code)
            op_tlbwi: store_entry(int'(idx_r));
            op_tlbwr: begin
                // slot follows Random so the entry is tracked by its vpn2
                slot = -1;
                for (int e = 0; e < tlb_entries; e++) begin
                    if (m_known[e] && m_vpn2[e] == hi_vpn2) begin
                        slot = e;
                    end
                end
                if (slot < 0) begin
                    for (int e = 0; e < tlb_entries; e++) begin
                        m_known[e] = 1'b0;
                    end
                    slot = 0;
                end
                store_entry(slot);
            end
            op_tlbr: begin
                hi_vpn2 = m_vpn2[idx_r];
                hi_asid = m_asid[idx_r];
                lo0 = with_g(m_lo0[idx_r], m_lo0[idx_r].f.g & m_lo1[idx_r].f.g);
                lo1 = with_g(m_lo1[idx_r], m_lo0[idx_r].f.g & m_lo1[idx_r].f.g);
            end
            default: begin
                model_find(hi_vpn2, found, slot);
                idx_p = !found;
                if (found) begin
                    idx_r = tlb_idx_w'(slot);
                end
            end
        endcase
    endtask

    task automatic run_xlate(input string name, input bit i_en, input logic [31:0] i_va,
                             input bit d_en, input logic [31:0] d_va, input bit d_wr);
        logic [31:0]      pa;
        logic [exc_w-1:0] ex;
        bit               ca;
        @(posedge clk);
        #10;
        inst_req   = i_en;
        inst_vaddr = i_va;
        data_req   = d_en;
        data_vaddr = d_va;
        data_wr    = d_wr;
        @(posedge clk);
        #10;
        inst_req = 1'b0;
        data_req = 1'b0;
        data_wr  = 1'b0;
        @(negedge clk);
        while ((i_en && !inst_done) || (d_en && !data_done)) begin
            @(negedge clk);
        end
        if (i_en) begin
            predict(i_va, 1'b0, pa, ex, ca);
            check_val({name, ".inst_exc"}, 32'(ex), 32'(inst_exc));
            check_val({name, ".inst_cached"}, 32'(ca), 32'(inst_cached));
            if (ex == exc_none) begin
                check_val({name, ".inst_paddr"}, pa, inst_paddr);
            end
        end
        if (d_en) begin
            predict(d_va, d_wr, pa, ex, ca);
            check_val({name, ".data_exc"}, 32'(ex), 32'(data_exc));
            check_val({name, ".data_cached"}, 32'(ca), 32'(data_cached));
            if (ex == exc_none) begin
                check_val({name, ".data_paddr"}, pa, data_paddr);
            end
        end
    endtask

    initial begin
        logic [31:0]          r;
        logic [tlb_idx_w-1:0] i;
        entrylo_u             lo_a;
        entrylo_u             lo_b;
        void'($urandom(32'h6eb2_3274));
        cp0_we     = 1'b0;
        cp0_addr   = '0;
        cp0_wdata  = '0;
        cp0_raddr  = '0;
        op_valid   = 1'b0;
        op_code    = '0;
        inst_req   = 1'b0;
        inst_vaddr = '0;
        data_req   = 1'b0;
        data_vaddr = '0;
        data_wr    = 1'b0;
        hi_vpn2    = '0;
        hi_asid    = '0;
        lo0        = '0;
        lo1        = '0;
        idx_p      = 1'b0;
        idx_r      = '0;
        for (int e = 0; e < tlb_entries; e++) begin
            m_known[e] = 1'b0;
        end
        wait (rst_n === 1'b1);
        read_check("reset_index", cp0_index, 32'h0);

        // random starts at 31 and counts down once per clock
        @(posedge clk);
        #10;
        cp0_raddr = cp0_random;
        @(negedge clk);
        check_val("reset_random", {27'b0, tlb_idx_w'(tlb_entries - 1 - live_edges)}, cp0_rdata);

        // fill every entry with unique vpn2s
        for (int e = 0; e < tlb_entries; e++) begin
            load_entry(fresh_vpn2(), random_asid(), rand_lo(), rand_lo());
            write_cp0(cp0_index, 32'(e));
            do_op(op_tlbwi);
        end

        for (int n = 0; n < n_kseg; n++) begin
            r = $urandom;
            run_xlate($sformatf("kseg%0d", n), 1'b1, unmapped_va(), 1'b1, unmapped_va(), r[0]);
        end

        for (int n = 0; n < n_map; n++) begin
            r = $urandom;
            // switch the current asid now and then
            if (r[2:0] == 3'd0) begin
                write_cp0(cp0_entryhi, {hi_vpn2, 5'b0, 6'b0, r[4:3]});
            end
            run_xlate($sformatf("map%0d", n), 1'b1, mapped_va(), 1'b1, mapped_va(), r[5]);
        end

        for (int n = 0; n < n_tlbr; n++) begin
            r = $urandom;
            write_cp0(cp0_index, {27'b0, r[4:0]});
            do_op(op_tlbr);
            read_check($sformatf("tlbr%0d.entryhi", n), cp0_entryhi, {hi_vpn2, 5'b0, hi_asid});
            read_check($sformatf("tlbr%0d.entrylo0", n), cp0_entrylo0, lo0.raw);
            read_check($sformatf("tlbr%0d.entrylo1", n), cp0_entrylo1, lo1.raw);
        end

        for (int n = 0; n < n_tlbp; n++) begin
            r = $urandom;
            if (r[0]) begin
                i = r[5:1];
                write_cp0(cp0_entryhi, {m_vpn2[i], 5'b0, m_asid[i]});
            end else begin
                write_cp0(cp0_entryhi, {fresh_vpn2(), 5'b0, 6'b0, r[7:6]});
            end
            do_op(op_tlbp);
            read_check($sformatf("tlbp%0d.index", n), cp0_index, {idx_p, 26'b0, idx_r});
        end

        for (int n = 0; n < n_tlbwr; n++) begin
            r = $urandom;
            lo_a = rand_lo();
            lo_b = rand_lo();
            lo_a.f.v = 1'b1;
            lo_b.f.v = 1'b1;
            load_entry(fresh_vpn2(), {6'b0, r[1:0]}, lo_a, lo_b);
            do_op(op_tlbwr);
            run_xlate($sformatf("tlbwr%0d", n), 1'b1, {hi_vpn2, 1'b0, r[13:2]},
                      1'b1, {hi_vpn2, 1'b1, r[25:14]}, r[26]);
        end

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
mmu_pkg.sv
mmu_ifs.sv
tlb_regs.sv
tlb_array.sv
addr_xlate.sv
mmu_top.sv
tb_clkgen.sv
mmu_checker.sv
mmu_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb -f vlog.f -o mmu_sim &&
./obj_dir/mmu_sim | tee /dev/stderr | grep -qx "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
